// ==== sim.f ====
+incdir+common
common/vga_pkg.sv
common/vga_timing_if.sv
vga/vga_timing.sv
vga/square_painter.sv
source/square_config.sv
source/vga_square_top.sv
tests/tb_vga_square.sv

// ==== Makefile ====
TOP = tb_vga_square

.PHONY: lint sim clean

lint:
	verilator --lint-only +incdir+common --top-module vga_square_top \
		common/vga_pkg.sv common/vga_timing_if.sv vga/vga_timing.sv \
		vga/square_painter.sv source/square_config.sv source/vga_square_top.sv

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee /dev/stderr | grep -q -F '** PASS **'

clean:
	rm -rf obj_dir

// ==== tests/tb_vga_square.sv ====
`timescale 1ns/10ps

`include "vga_consts.svh"

module tb_vga_square
    import vga_pkg::*;
();

    localparam logic [9:0] H_LAST     = `VGA_H_TOTAL - 10'd1;
    localparam logic [9:0] V_LAST     = `VGA_V_TOTAL - 10'd1;
    localparam logic [9:0] H_SYNC_BEG = `VGA_H_VISIBLE + `VGA_H_FRONT;
    localparam logic [9:0] H_SYNC_END = H_SYNC_BEG + `VGA_H_SYNC;
    localparam logic [9:0] V_SYNC_BEG = `VGA_V_VISIBLE + `VGA_V_FRONT;
    localparam logic [9:0] V_SYNC_END = V_SYNC_BEG + `VGA_V_SYNC;
    localparam int         ACK_LIMIT   = 16;
    localparam int         FRAME_LIMIT = 900000; // A bit over two frames.

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      cfg_req;
    cfg_addr_t                 cfg_addr;
    logic [`VGA_CFG_WIDTH-1:0] cfg_data;
    logic                      cfg_ack;
    logic                      hsync;
    logic                      vsync;
    logic [2:0]                rgb;

    logic [9:0]  tb_h       = '0;     // Pixel shown on the outputs.
    logic [9:0]  tb_v       = '0;
    logic [9:0]  h_pred     = '0;
    logic [9:0]  v_pred     = '0;
    logic        h_lock     = 1'b0;
    logic        v_lock     = 1'b0;
    logic        h_chk      = 1'b0;
    logic        v_chk      = 1'b0;
    logic        v_fall     = 1'b0;
    logic        prev_hsync = 1'b1;
    logic        prev_vsync = 1'b1;
    logic [2:0]  exp_rgb    = '0;
    logic [9:0]  m_x        = `VGA_RST_X;
    logic [9:0]  m_y        = `VGA_RST_Y;
    logic [9:0]  m_size     = `VGA_RST_SIZE;
    logic [2:0]  m_fg       = `VGA_RST_FG;
    logic [2:0]  m_bg       = `VGA_RST_BG;
    logic [9:0]  p_x        = `VGA_RST_X;
    logic [9:0]  p_y        = `VGA_RST_Y;
    logic [9:0]  p_size     = `VGA_RST_SIZE;
    logic [2:0]  p_fg       = `VGA_RST_FG;
    logic [2:0]  p_bg       = `VGA_RST_BG;
    int          p_seq      = 0;      // Acked write sets.
    int          m_seq      = 0;      // Write sets in the model.
    logic [31:0] rng_state  = 32'd23651;

    vga_square_top vga_square_top_inst (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cfg_req  ( cfg_req  ),
        .cfg_addr ( cfg_addr ),
        .cfg_data ( cfg_data ),
        .cfg_ack  ( cfg_ack  ),
        .hsync    ( hsync    ),
        .vsync    ( vsync    ),
        .rgb      ( rgb      )
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [2:0] pixel_colour(input logic [9:0] h, input logic [9:0] v);
        logic in_sq;
        if (h >= `VGA_H_VISIBLE || v >= `VGA_V_VISIBLE) begin
            return 3'b000;
        end
        in_sq = (int'(h) >= int'(m_x)) && (int'(h) < int'(m_x) + int'(m_size)) &&
                (int'(v) >= int'(m_y)) && (int'(v) < int'(m_y) + int'(m_size));
        return in_sq ? m_fg : m_bg;
    endfunction

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    // Outputs are stable here, half a cycle after the DUT register.
    always @(negedge clk) begin : track_position
        logic [9:0] h_n;
        logic [9:0] v_n;
        logic       hf;
        logic       vf;
        h_n = (tb_h == H_LAST) ? 10'd0 : tb_h + 10'd1;
        v_n = tb_v;
        if (h_n == 10'd0) begin
            v_n = (tb_v == V_LAST) ? 10'd0 : tb_v + 10'd1;
        end
        hf = prev_hsync && !hsync;
        vf = prev_vsync && !vsync;
        h_pred <= h_n;
        v_pred <= v_n;
        h_chk  <= hf && h_lock;
        v_chk  <= vf && v_lock;
        if (hf) begin
            h_n = H_SYNC_BEG;
            h_lock <= 1'b1;
        end
        if (vf && h_lock) begin
            v_n = V_SYNC_BEG;
            v_lock <= 1'b1;
        end
        tb_h       <= h_n;
        tb_v       <= v_n;
        prev_hsync <= hsync;
        prev_vsync <= vsync;
        v_fall     <= vf;
        exp_rgb    <= pixel_colour(h_n, v_n);
        if (vf && m_seq != p_seq) begin
            m_x    <= p_x;
            m_y    <= p_y;
            m_size <= p_size;
            m_fg   <= p_fg;
            m_bg   <= p_bg;
            m_seq  <= p_seq;
        end
    end

    task automatic host_write(input cfg_addr_t addr, input cfg_word_t data);
        int cnt;
        cfg_addr = addr;
        cfg_data = data;
        cfg_req  = 1'b1;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > ACK_LIMIT) stop_on_error("Handshake timeout, cfg_ack never rose.");
        end while (!cfg_ack);
        cfg_req = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > ACK_LIMIT) stop_on_error("Handshake timeout, cfg_ack never fell.");
        end while (cfg_ack);
    endtask

    task automatic wait_line(input logic [9:0] line);
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > FRAME_LIMIT) stop_on_error("Timeout waiting for a display line.");
        end while (!(v_lock && tb_v == line && tb_h == 10'd0));
    endtask

    task automatic wait_frame_end();
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > FRAME_LIMIT) stop_on_error("Timeout waiting for a vsync falling edge.");
        end while (!v_fall);
    endtask

    // Random square kept fully inside the visible area.
    task automatic random_square();
        int         size_i;
        int         x_i;
        int         y_i;
        logic [2:0] fg_v;
        logic [2:0] bg_v;
        cfg_word_t  w;
        rng_state = xorshift32(rng_state);
        size_i = 16 + int'(rng_state[6:0]) % 112;
        rng_state = xorshift32(rng_state);
        x_i = int'(rng_state[15:0]) % (int'(`VGA_H_VISIBLE) - size_i);
        y_i = int'(rng_state[31:16]) % (int'(`VGA_V_VISIBLE) - size_i);
        rng_state = xorshift32(rng_state);
        fg_v = rng_state[2:0];
        bg_v = (rng_state[5:3] == fg_v) ? ~fg_v : rng_state[5:3];
        $display("Square x=%0d y=%0d size=%0d fg=%0d bg=%0d", x_i, y_i, size_i, fg_v, bg_v);
        w = '0;
        w.pos.x = 10'(x_i);
        w.pos.y = 10'(y_i);
        host_write(CFG_POS, w);
        w = '0;
        w.style.fg   = fg_v;
        w.style.bg   = bg_v;
        w.style.size = 10'(size_i);
        host_write(CFG_STYLE, w);
        p_x    <= 10'(x_i);
        p_y    <= 10'(y_i);
        p_size <= 10'(size_i);
        p_fg   <= fg_v;
        p_bg   <= bg_v;
        p_seq  <= p_seq + 1;
    endtask

    a_hsync_level: assert property (@(posedge clk) disable iff (!rst_n)
        h_lock |-> (hsync == !(tb_h >= H_SYNC_BEG && tb_h < H_SYNC_END)))
        else stop_on_error($sformatf("Fail at %0t ns: hsync %b at pixel %0d.",
                                     $time, $sampled(hsync), tb_h));

    a_hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        h_chk |-> (h_pred == H_SYNC_BEG))
        else stop_on_error($sformatf("Fail at %0t ns: hsync fell at pixel %0d.", $time, h_pred));

    a_vsync_level: assert property (@(posedge clk) disable iff (!rst_n)
        v_lock |-> (vsync == !(tb_v >= V_SYNC_BEG && tb_v < V_SYNC_END)))
        else stop_on_error($sformatf("Fail at %0t ns: vsync %b at line %0d.",
                                     $time, $sampled(vsync), tb_v));

    a_vsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        v_chk |-> (v_pred == V_SYNC_BEG && h_pred == 10'd0))
        else stop_on_error($sformatf("Fail at %0t ns: vsync fell at (%0d,%0d).",
                                     $time, h_pred, v_pred));

    a_pixel: assert property (@(posedge clk) disable iff (!rst_n)
        v_lock |-> (rgb == exp_rgb))
        else stop_on_error($sformatf("Fail at %0t ns: rgb %0d, expected %0d at (%0d,%0d).",
                                     $time, $sampled(rgb), exp_rgb, tb_h, tb_v));

    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cfg_ack) |-> $past(cfg_req))
        else stop_on_error($sformatf("Fail at %0t ns: cfg_ack rose without cfg_req.", $time));

    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cfg_ack) |-> !$past(cfg_req))
        else stop_on_error($sformatf("Fail at %0t ns: cfg_ack fell while cfg_req high.", $time));

    a_ack_follow: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cfg_req) |=> cfg_ack)
        else stop_on_error($sformatf("Fail at %0t ns: cfg_ack late after cfg_req.", $time));

    a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(cfg_req) |=> !cfg_ack)
        else stop_on_error($sformatf("Fail at %0t ns: cfg_ack held after release.", $time));

    initial begin
        rst_n    = 1'b0;
        cfg_req  = 1'b0;
        cfg_addr = CFG_POS;
        cfg_data = '0;
        repeat (4) @(negedge clk);
        a_reset_state: assert (!cfg_ack && hsync && vsync && rgb == 3'b000)
            else stop_on_error($sformatf("Fail at %0t ns: outputs not idle in reset.", $time));
        rst_n = 1'b1;
        wait_frame_end();   // Frame 0 ends, counters lock.
        wait_line(10'd240); // Frame 1 keeps the reset square.
        random_square();
        wait_frame_end();
        wait_line(10'd240);
        random_square();
        wait_frame_end();
        wait_frame_end();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== source/vga_square_top.sv ====
`timescale 1ns/10ps

`include "vga_consts.svh"

module vga_square_top
    import vga_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_req,
    input  cfg_addr_t                 cfg_addr,
    input  logic [`VGA_CFG_WIDTH-1:0] cfg_data,
    output logic                      cfg_ack,
    output logic                      hsync,
    output logic                      vsync,
    output logic [2:0]                rgb
);

    vga_timing_if              tim ();

    logic [`VGA_POS_WIDTH-1:0] sq_x;
    logic [`VGA_POS_WIDTH-1:0] sq_y;
    logic [`VGA_POS_WIDTH-1:0] sq_size;
    logic [2:0]                fg;
    logic [2:0]                bg;

    vga_timing vga_timing_inst (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .tim   ( tim   )
    );

    square_config square_config_inst (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cfg_req  ( cfg_req  ),
        .cfg_addr ( cfg_addr ),
        .cfg_data ( cfg_data ),
        .tim      ( tim      ),
        .cfg_ack  ( cfg_ack  ),
        .sq_x     ( sq_x     ),
        .sq_y     ( sq_y     ),
        .sq_size  ( sq_size  ),
        .fg       ( fg       ),
        .bg       ( bg       )
    );

    square_painter square_painter_inst (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .tim     ( tim     ),
        .sq_x    ( sq_x    ),
        .sq_y    ( sq_y    ),
        .sq_size ( sq_size ),
        .fg      ( fg      ),
        .bg      ( bg      ),
        .hsync   ( hsync   ),
        .vsync   ( vsync   ),
        .rgb     ( rgb     )
    );

endmodule

// ==== source/square_config.sv ====
`timescale 1ns/10ps

`include "vga_consts.svh"

module square_config
    import vga_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cfg_req,
    input  cfg_addr_t                 cfg_addr,
    input  logic [`VGA_CFG_WIDTH-1:0] cfg_data,
    vga_timing_if.frame               tim,
    output logic                      cfg_ack,
    output logic [`VGA_POS_WIDTH-1:0] sq_x,
    output logic [`VGA_POS_WIDTH-1:0] sq_y,
    output logic [`VGA_POS_WIDTH-1:0] sq_size,
    output logic [2:0]                fg,
    output logic [2:0]                bg
);

    cfg_word_t                 word;
    logic                      wr_en;
    logic [`VGA_POS_WIDTH-1:0] pend_x;
    logic [`VGA_POS_WIDTH-1:0] pend_y;
    logic [`VGA_POS_WIDTH-1:0] pend_size;
    logic [2:0]                pend_fg;
    logic [2:0]                pend_bg;

    assign word  = cfg_data;
    assign wr_en = cfg_req && !cfg_ack; // First phase only.

    // Ack tracks req one cycle late.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_ack <= 1'b0;
        end else begin
            cfg_ack <= cfg_req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_x    <= `VGA_RST_X;
            pend_y    <= `VGA_RST_Y;
            pend_size <= `VGA_RST_SIZE;
            pend_fg   <= `VGA_RST_FG;
            pend_bg   <= `VGA_RST_BG;
        end else if (wr_en) begin
            if (cfg_addr == CFG_POS) begin
                pend_x <= word.pos.x;
                pend_y <= word.pos.y;
            end else begin
                pend_size <= word.style.size;
                pend_fg   <= word.style.fg;
                pend_bg   <= word.style.bg;
            end
        end
    end

    // Applied set changes only between frames.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sq_x    <= `VGA_RST_X;
            sq_y    <= `VGA_RST_Y;
            sq_size <= `VGA_RST_SIZE;
            fg      <= `VGA_RST_FG;
            bg      <= `VGA_RST_BG;
        end else if (tim.frame_start) begin
            sq_x    <= pend_x;
            sq_y    <= pend_y;
            sq_size <= pend_size;
            fg      <= pend_fg;
            bg      <= pend_bg;
        end
    end

    a_ack_after_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(cfg_ack) |-> $past(cfg_req)
    ) else $error("Ack raised without a request.");

    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cfg_req && $past(cfg_req && !cfg_ack)) |-> ($stable(cfg_addr) && $stable(cfg_data))
    ) else $error("Host changed address or data during a request.");

endmodule

// ==== vga/square_painter.sv ====
`timescale 1ns/10ps

`include "vga_consts.svh"

module square_painter (
    input  logic                      clk,
    input  logic                      rst_n,
    vga_timing_if.sink                tim,
    input  logic [`VGA_POS_WIDTH-1:0] sq_x,
    input  logic [`VGA_POS_WIDTH-1:0] sq_y,
    input  logic [`VGA_POS_WIDTH-1:0] sq_size,
    input  logic [2:0]                fg,
    input  logic [2:0]                bg,
    output logic                      hsync,
    output logic                      vsync,
    output logic [2:0]                rgb
);

    logic [`VGA_POS_WIDTH:0] x_end; // One extra bit, no wrap.
    logic [`VGA_POS_WIDTH:0] y_end;
    logic                    in_x;
    logic                    in_y;
    logic [2:0]              pixel;
    logic                    de_q;

    assign x_end = {1'b0, sq_x} + {1'b0, sq_size};
    assign y_end = {1'b0, sq_y} + {1'b0, sq_size};

    assign in_x = (tim.hpos >= sq_x) && ({1'b0, tim.hpos} < x_end);
    assign in_y = (tim.vpos >= sq_y) && ({1'b0, tim.vpos} < y_end);

    always_comb begin
        if (!tim.display_on) begin
            pixel = 3'b000; // Blanking.
        end else if (in_x && in_y) begin
            pixel = fg;
        end else begin
            pixel = bg;
        end
    end

    // Colour and syncs share one register stage.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            rgb   <= 3'b000;
            de_q  <= 1'b0;
        end else begin
            hsync <= tim.hsync;
            vsync <= tim.vsync;
            rgb   <= pixel;
            de_q  <= tim.display_on;
        end
    end

    a_blank_black: assert property (
        @(posedge clk) disable iff (!rst_n)
        !de_q |-> (rgb == 3'b000)
    ) else $error("Colour driven outside the visible area.");

endmodule

// ==== vga/vga_timing.sv ====
`timescale 1ns/10ps

`include "vga_consts.svh"

module vga_timing (
    input  logic       clk,
    input  logic       rst_n,
    vga_timing_if.src  tim
);

    logic [`VGA_POS_WIDTH-1:0] h_cnt;
    logic [`VGA_POS_WIDTH-1:0] v_cnt;
    logic                      h_last;
    logic                      v_last;
    logic                      h_pulse;
    logic                      v_pulse;

    assign h_last = (h_cnt == `VGA_H_TOTAL - 1'b1);
    assign v_last = (v_cnt == `VGA_V_TOTAL - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1; // Next line.
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Sync pulses sit after the front porch.
    assign h_pulse = (h_cnt >= `VGA_H_VISIBLE + `VGA_H_FRONT) &&
                     (h_cnt <  `VGA_H_VISIBLE + `VGA_H_FRONT + `VGA_H_SYNC);
    assign v_pulse = (v_cnt >= `VGA_V_VISIBLE + `VGA_V_FRONT) &&
                     (v_cnt <  `VGA_V_VISIBLE + `VGA_V_FRONT + `VGA_V_SYNC);

    assign tim.hsync       = ~h_pulse;
    assign tim.vsync       = ~v_pulse;
    assign tim.display_on  = (h_cnt < `VGA_H_VISIBLE) && (v_cnt < `VGA_V_VISIBLE);
    assign tim.hpos        = h_cnt;
    assign tim.vpos        = v_cnt;
    assign tim.frame_start = h_last && v_last; // Both counters wrap next.

    a_pos_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (h_cnt < `VGA_H_TOTAL) && (v_cnt < `VGA_V_TOTAL)
    ) else $error("Timing counter out of range.");

endmodule

// ==== common/vga_timing_if.sv ====
`timescale 1ns/10ps

`include "vga_consts.svh"

interface vga_timing_if;

    logic                      hsync;       // Active low.
    logic                      vsync;       // Active low.
    logic                      display_on;
    logic [`VGA_POS_WIDTH-1:0] hpos;
    logic [`VGA_POS_WIDTH-1:0] vpos;
    logic                      frame_start; // Last pixel of the frame.

    modport src (
        output hsync, vsync, display_on, hpos, vpos, frame_start
    );

    modport sink (
        input hsync, vsync, display_on, hpos, vpos
    );

    modport frame (input frame_start);

endinterface

// ==== common/vga_pkg.sv ====
`include "vga_consts.svh"

package vga_pkg;

    // Register select on the host port.
    typedef enum logic {
        CFG_POS   = 1'b0,
        CFG_STYLE = 1'b1
    } cfg_addr_t;

    // One host data word, read as pos or as style by cfg_addr.
    typedef union packed {
        struct packed {
            logic [`VGA_POS_WIDTH-1:0] x;
            logic [`VGA_POS_WIDTH-1:0] y;
        } pos;
        struct packed {
            logic [3:0]                unused;
            logic [2:0]                fg;
            logic [2:0]                bg;
            logic [`VGA_POS_WIDTH-1:0] size;
        } style;
    } cfg_word_t;

endpackage

// ==== common/vga_consts.svh ====
`ifndef VGA_CONSTS_SVH
`define VGA_CONSTS_SVH

// 640x480 at 60 Hz, 25 MHz pixel clock.
`define VGA_H_VISIBLE 10'd640
`define VGA_H_FRONT   10'd16
`define VGA_H_SYNC    10'd96
`define VGA_H_BACK    10'd48
`define VGA_H_TOTAL   10'd800

`define VGA_V_VISIBLE 10'd480
`define VGA_V_FRONT   10'd10
`define VGA_V_SYNC    10'd2
`define VGA_V_BACK    10'd33
`define VGA_V_TOTAL   10'd525

`define VGA_POS_WIDTH 10
`define VGA_CFG_WIDTH 20

// Square shown after reset.
`define VGA_RST_X     10'd100
`define VGA_RST_Y     10'd100
`define VGA_RST_SIZE  10'd64
`define VGA_RST_FG    3'b100
`define VGA_RST_BG    3'b001

`endif
